// File: rv32i_types.sv
package rv32i_types;

    // Issue width and register file sizes
    localparam int SS              = 2;
    localparam int NUM_ARCH_REGS   = 32;
    localparam int NUM_PHYS_REGS   = 64;
    localparam int ARCH_W          = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_W          = $clog2(NUM_PHYS_REGS);

    // Queue sizing
    localparam int IQ_DEPTH        = 8;
    localparam int FREE_LIST_DEPTH = 32;
    localparam int FREE_CNT_W      = $clog2(FREE_LIST_DEPTH) + 1;

    // First tag handed out by the free list
    localparam int FREE_TAG_BASE   = NUM_ARCH_REGS;

    typedef logic [PHYS_W-1:0] phys_reg_t;
    typedef logic [ARCH_W-1:0] arch_reg_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_br       = 7'b1100011,
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_imm      = 7'b0010011,
        op_reg      = 7'b0110011,
        op_misc_mem = 7'b0001111,
        op_system   = 7'b1110011
    } rv32i_opcode_t;

    // One decoded instruction
    typedef struct packed {
        logic [31:0]   pc;
        logic [31:0]   inst;
        rv32i_opcode_t opcode;
        arch_reg_t     rd;
        arch_reg_t     rs1;
        arch_reg_t     rs2;
        logic [31:0]   imm;
        logic          uses_rs1;
        logic          uses_rs2;
        logic          writes_rd;
    } inst_info_t;

    // Packed so one queue entry can be cast like any other payload
    typedef inst_info_t [SS-1:0] inst_pair_t;

    // One renamed slot of the dispatch packet
    typedef struct packed {
        logic [31:0] pc;
        arch_reg_t   rd;
        phys_reg_t   ps1;
        phys_reg_t   ps2;
        phys_reg_t   pd;
    } dispatch_t;

    // Free list entry idx holds tag 32 + idx at reset
    function automatic phys_reg_t free_tag(input int unsigned idx);
        return phys_reg_t'(FREE_TAG_BASE + idx);
    endfunction

endpackage

// File: rat_if.sv
interface rat_if;

    // Architectural indices from the rename stage
    rv32i_types::arch_reg_t isa_rs1 [rv32i_types::SS];
    rv32i_types::arch_reg_t isa_rs2 [rv32i_types::SS];
    rv32i_types::arch_reg_t isa_rd  [rv32i_types::SS];

    // Current mappings of the sources
    rv32i_types::phys_reg_t rat_rs1 [rv32i_types::SS];
    rv32i_types::phys_reg_t rat_rs2 [rv32i_types::SS];

    // New destination tags and their write enables
    rv32i_types::phys_reg_t rat_rd  [rv32i_types::SS];
    logic                   regf_we [rv32i_types::SS];

    modport rename (
        output isa_rs1, isa_rs2, isa_rd, rat_rd, regf_we,
        input  rat_rs1, rat_rs2
    );

    modport alias_table (
        input  isa_rs1, isa_rs2, isa_rd, rat_rd, regf_we,
        output rat_rs1, rat_rs2
    );

endinterface

// File: fetch_stage.sv
module fetch_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        accept,
    output logic [31:0] pc
);

    // No redirect path, PC only walks forward
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= 32'h0;
        end else if (accept) begin
            // Word accepted, move to next word
            pc <= pc + 32'd4;
        end
    end

endmodule

// File: id_stage.sv
module id_stage (
    input  logic [31:0]            pc,
    input  logic [31:0]            imem_rdata,
    output rv32i_types::inst_info_t instruction_info
);

    rv32i_types::rv32i_opcode_t opcode;
    logic [31:0]               imm_i;
    logic [31:0]               imm_s;
    logic [31:0]               imm_b;
    logic [31:0]               imm_u;
    logic [31:0]               imm_j;

    assign opcode = rv32i_types::rv32i_opcode_t'(imem_rdata[6:0]);

    // Immediates for each format, sign extended from bit 31
    assign imm_i = {{21{imem_rdata[31]}}, imem_rdata[30:20]};
    assign imm_s = {{21{imem_rdata[31]}}, imem_rdata[30:25], imem_rdata[11:7]};
    assign imm_b = {{20{imem_rdata[31]}}, imem_rdata[7], imem_rdata[30:25],
                    imem_rdata[11:8], 1'b0};
    assign imm_u = {imem_rdata[31:12], 12'h000};
    assign imm_j = {{12{imem_rdata[31]}}, imem_rdata[19:12], imem_rdata[20],
                    imem_rdata[30:21], 1'b0};

    always_comb begin
        instruction_info.pc     = pc;
        instruction_info.inst   = imem_rdata;
        instruction_info.opcode = opcode;
        instruction_info.rd     = imem_rdata[11:7];
        instruction_info.rs1    = imem_rdata[19:15];
        instruction_info.rs2    = imem_rdata[24:20];
        instruction_info.imm    = imm_i;
        // Default is an I-type with no register use
        instruction_info.uses_rs1  = 1'b0;
        instruction_info.uses_rs2  = 1'b0;
        instruction_info.writes_rd = 1'b0;
        unique case (opcode)
            rv32i_types::op_lui, rv32i_types::op_auipc: begin
                instruction_info.imm       = imm_u;
                instruction_info.writes_rd = 1'b1;
            end
            rv32i_types::op_jal: begin
                instruction_info.imm       = imm_j;
                instruction_info.writes_rd = 1'b1;
            end
            rv32i_types::op_jalr, rv32i_types::op_load, rv32i_types::op_imm: begin
                instruction_info.uses_rs1  = 1'b1;
                instruction_info.writes_rd = 1'b1;
            end
            rv32i_types::op_br: begin
                instruction_info.imm      = imm_b;
                instruction_info.uses_rs1 = 1'b1;
                instruction_info.uses_rs2 = 1'b1;
            end
            rv32i_types::op_store: begin
                instruction_info.imm      = imm_s;
                instruction_info.uses_rs1 = 1'b1;
                instruction_info.uses_rs2 = 1'b1;
            end
            rv32i_types::op_reg: begin
                instruction_info.uses_rs1  = 1'b1;
                instruction_info.uses_rs2  = 1'b1;
                instruction_info.writes_rd = 1'b1;
            end
            default: begin
                // Fence and system words take no rename resources
            end
        endcase
        // x0 is never renamed
        if (instruction_info.rd == '0) begin
            instruction_info.writes_rd = 1'b0;
        end
    end

endmodule

// File: two_inst_buff.sv
module two_inst_buff (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  rv32i_types::inst_info_t decoded_inst,
    output rv32i_types::inst_pair_t valid_inst,
    output logic                    valid_out
);

    localparam int SLOT_W = $clog2(rv32i_types::SS);

    logic [SLOT_W-1:0]       slot;
    rv32i_types::inst_pair_t partial;
    rv32i_types::inst_pair_t next_pair;
    logic                    last_slot;

    assign last_slot = (slot == SLOT_W'(rv32i_types::SS - 1));

    // Pair as it looks with the incoming word dropped in
    always_comb begin
        next_pair       = partial;
        next_pair[slot] = decoded_inst;
    end

    // Slot pointer and push strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot      <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid && last_slot;
            if (valid) begin
                slot <= last_slot ? '0 : slot + SLOT_W'(1);
            end
        end
    end

    // Payload registers, output pair held until the next one completes
    always_ff @(posedge clk) begin
        if (valid) begin
            partial <= next_pair;
            if (last_slot) begin
                valid_inst <= next_pair;
            end
        end
    end

endmodule

// File: circular_queue.sv
module circular_queue #(
    parameter type QUEUE_TYPE   = rv32i_types::inst_pair_t,
    parameter int  DEPTH        = rv32i_types::IQ_DEPTH,
    parameter int  ELEMS_PER_OP = 1,
    parameter bit  INIT_FREE    = 1'b0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  logic                           pop,
    input  QUEUE_TYPE                      in    [rv32i_types::SS],
    output QUEUE_TYPE                      out   [rv32i_types::SS],
    output logic                           full,
    output logic                           empty,
    output logic [$clog2(DEPTH):0]         count
);

    localparam int AW    = $clog2(DEPTH);
    localparam int PTR_W = AW + 1;

    QUEUE_TYPE        mem [DEPTH];
    // Extra top bit tells a full queue from an empty one
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic             do_push;
    logic             do_pop;

    function automatic logic [AW-1:0] wrap_idx(input logic [PTR_W-1:0] ptr, input int ofs);
        return ptr[AW-1:0] + AW'(ofs);
    endfunction

    assign count = tail - head;
    assign empty = (count == '0);
    // Full once another operation's worth would not fit
    assign full  = (int'(count) > DEPTH - ELEMS_PER_OP);

    // Illegal requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && (int'(count) >= ELEMS_PER_OP);

    // Head entries visible without a pop
    always_comb begin
        for (int i = 0; i < rv32i_types::SS; i++) begin
            out[i] = mem[wrap_idx(head, i)];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
            // Free list comes out of reset holding every entry
            tail <= INIT_FREE ? PTR_W'(DEPTH) : '0;
        end else begin
            if (do_push) begin
                tail <= tail + PTR_W'(ELEMS_PER_OP);
            end
            if (do_pop) begin
                head <= head + PTR_W'(ELEMS_PER_OP);
            end
        end
    end

    // Storage, only the free list is loaded at reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if (INIT_FREE) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= QUEUE_TYPE'(rv32i_types::free_tag(i));
                end
            end
        end else if (do_push) begin
            for (int i = 0; i < ELEMS_PER_OP; i++) begin
                mem[wrap_idx(tail, i)] <= in[i];
            end
        end
    end

endmodule

// File: rat.sv
module rat (
    input logic        clk,
    input logic        rst_n,
    rat_if.alias_table rat
);

    rv32i_types::phys_reg_t map [rv32i_types::NUM_ARCH_REGS];

    // Lookups see the table before this cycle's writes
    always_comb begin
        for (int i = 0; i < rv32i_types::SS; i++) begin
            rat.rat_rs1[i] = map[rat.isa_rs1[i]];
            rat.rat_rs2[i] = map[rat.isa_rs2[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Identity mapping, register i lives in tag i
            for (int i = 0; i < rv32i_types::NUM_ARCH_REGS; i++) begin
                map[i] <= rv32i_types::phys_reg_t'(i);
            end
        end else begin
            // Later slot written last so it wins on the same index
            for (int i = 0; i < rv32i_types::SS; i++) begin
                if (rat.regf_we[i]) begin
                    map[rat.isa_rd[i]] <= rat.rat_rd[i];
                end
            end
        end
    end

endmodule

// File: rename_dispatch.sv
module rename_dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  rv32i_types::inst_pair_t                instruction,
    input  logic                                   inst_q_empty,
    input  rv32i_types::phys_reg_t                 free_list_regs [rv32i_types::SS],
    input  logic [rv32i_types::FREE_CNT_W-1:0]     free_count,
    input  logic                                   rs_full,
    rat_if.rename                                  rat,
    output logic                                   pop_inst_q,
    output rv32i_types::dispatch_t                 rs_entries [rv32i_types::SS],
    output logic                                   dispatch_valid
);

    rv32i_types::dispatch_t next_entries [rv32i_types::SS];

    // Pop both queues together when a pair, tags and room are all there
    assign pop_inst_q = !inst_q_empty && !rs_full &&
                        (free_count >= rv32i_types::FREE_CNT_W'(rv32i_types::SS));

    always_comb begin
        for (int i = 0; i < rv32i_types::SS; i++) begin
            // Table lookups and updates
            rat.isa_rs1[i] = instruction[i].rs1;
            rat.isa_rs2[i] = instruction[i].rs2;
            rat.isa_rd[i]  = instruction[i].rd;
            rat.rat_rd[i]  = free_list_regs[i];
            rat.regf_we[i] = pop_inst_q && instruction[i].writes_rd;

            next_entries[i].pc  = instruction[i].pc;
            next_entries[i].rd  = instruction[i].rd;
            // Unused sources and non-writing slots carry tag 0
            next_entries[i].ps1 = instruction[i].uses_rs1 ? rat.rat_rs1[i] : '0;
            next_entries[i].ps2 = instruction[i].uses_rs2 ? rat.rat_rs2[i] : '0;
            // Popped tag is simply dropped when nothing is written
            next_entries[i].pd  = instruction[i].writes_rd ? free_list_regs[i] : '0;

            // In-pair bypass, the nearest older writer wins
            for (int j = 0; j < i; j++) begin
                if (instruction[j].writes_rd && instruction[i].uses_rs1 &&
                    instruction[i].rs1 == instruction[j].rd) begin
                    next_entries[i].ps1 = free_list_regs[j];
                end
                if (instruction[j].writes_rd && instruction[i].uses_rs2 &&
                    instruction[i].rs2 == instruction[j].rd) begin
                    next_entries[i].ps2 = free_list_regs[j];
                end
            end
        end
    end

    // One-cycle pulse per pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= pop_inst_q;
        end
    end

    // Packet register
    always_ff @(posedge clk) begin
        if (pop_inst_q) begin
            rs_entries <= next_entries;
        end
    end

endmodule

// File: cpu.sv
module cpu (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    output logic [3:0]  imem_rmask,
    input  logic [31:0] imem_rdata,
    input  logic        imem_resp,
    input  logic        rs_full,
    output logic        dispatch_valid,
    output logic [31:0] dispatch_pc  [rv32i_types::SS],
    output logic [4:0]  dispatch_rd  [rv32i_types::SS],
    output logic [5:0]  dispatch_ps1 [rv32i_types::SS],
    output logic [5:0]  dispatch_ps2 [rv32i_types::SS],
    output logic [5:0]  dispatch_pd  [rv32i_types::SS]
);

    logic                                 accept;
    logic [31:0]                          pc;
    rv32i_types::inst_info_t              decoded_inst;
    rv32i_types::inst_pair_t              buf_pair;
    logic                                 buf_push;
    rv32i_types::inst_pair_t              iq_in      [rv32i_types::SS];
    rv32i_types::inst_pair_t              iq_out     [rv32i_types::SS];
    logic                                 iq_full;
    logic                                 iq_empty;
    logic                                 pop_inst_q;
    rv32i_types::phys_reg_t               fl_in      [rv32i_types::SS];
    rv32i_types::phys_reg_t               fl_regs    [rv32i_types::SS];
    logic [rv32i_types::FREE_CNT_W-1:0]   fl_count;
    rv32i_types::dispatch_t               rs_entries [rv32i_types::SS];

    rat_if rat_bus ();

    // Word taken only while the instruction queue has room
    assign accept     = imem_resp && !iq_full;
    assign imem_addr  = pc;
    assign imem_rmask = 4'hf;

    // Queue pushes one pair from element 0, free list is never pushed
    assign iq_in = '{default: buf_pair};
    assign fl_in = '{default: '0};

    fetch_stage fetch_stage_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .accept (accept),
        .pc     (pc)
    );

    id_stage id_stage_i (
        .pc               (pc),
        .imem_rdata       (imem_rdata),
        .instruction_info (decoded_inst)
    );

    two_inst_buff buff (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (accept),
        .decoded_inst (decoded_inst),
        .valid_inst   (buf_pair),
        .valid_out    (buf_push)
    );

    circular_queue #(
        .QUEUE_TYPE   (rv32i_types::inst_pair_t),
        .DEPTH        (rv32i_types::IQ_DEPTH),
        .ELEMS_PER_OP (1),
        .INIT_FREE    (1'b0)
    ) instruction_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (buf_push),
        .pop   (pop_inst_q),
        .in    (iq_in),
        .out   (iq_out),
        .full  (iq_full),
        .empty (iq_empty),
        .count ()
    );

    circular_queue #(
        .QUEUE_TYPE   (rv32i_types::phys_reg_t),
        .DEPTH        (rv32i_types::FREE_LIST_DEPTH),
        .ELEMS_PER_OP (rv32i_types::SS),
        .INIT_FREE    (1'b1)
    ) free_list (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (1'b0),
        .pop   (pop_inst_q),
        .in    (fl_in),
        .out   (fl_regs),
        .full  (),
        .empty (),
        .count (fl_count)
    );

    rat rt (
        .clk   (clk),
        .rst_n (rst_n),
        .rat   (rat_bus.alias_table)
    );

    rename_dispatch rd (
        .clk            (clk),
        .rst_n          (rst_n),
        .instruction    (iq_out[0]),
        .inst_q_empty   (iq_empty),
        .free_list_regs (fl_regs),
        .free_count     (fl_count),
        .rs_full        (rs_full),
        .rat            (rat_bus.rename),
        .pop_inst_q     (pop_inst_q),
        .rs_entries     (rs_entries),
        .dispatch_valid (dispatch_valid)
    );

    // Packet out to the plain ports
    for (genvar i = 0; i < rv32i_types::SS; i++) begin : g_fanout
        assign dispatch_pc[i]  = rs_entries[i].pc;
        assign dispatch_rd[i]  = rs_entries[i].rd;
        assign dispatch_ps1[i] = rs_entries[i].ps1;
        assign dispatch_ps2[i] = rs_entries[i].ps2;
        assign dispatch_pd[i]  = rs_entries[i].pd;
    end

endmodule

// File: tb_clkgen.sv
module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    logic rst_n_r = 1'b0;

    assign rst_n = rst_n_r;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low over the first four rising edges
    initial begin
        repeat (4) @(posedge clk);
        rst_n_r <= 1'b1;
    end

endmodule

// File: cpu_chk.sv
module cpu_chk (
    input logic clk,
    input logic rst_n,
    input logic push,
    input logic queue_full,
    input logic pop,
    input logic queue_empty,
    input logic rs_full,
    input logic dispatch_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Fetch must have stalled before the queue filled
    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && queue_full))
        else $error("instruction queue pushed while full");

    // Rename only pops a real pair with room downstream
    pop_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && (queue_empty || rs_full)))
        else $error("instruction queue popped while empty or rs_full high");

    // Exactly one dispatch cycle for each pop
    dispatch_per_pop: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid == $past(pop))
        else $error("dispatch_valid does not follow pop by one cycle");

endmodule

// File: cpu_tb.sv
module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SS             = rv32i_types::SS;
    localparam int NUM_WORDS      = 64;
    localparam int NUM_PAIRS      = rv32i_types::FREE_LIST_DEPTH / SS;
    localparam int BP_START       = 6;
    localparam int BP_MIN         = 10;
    localparam int BP_MAX         = 30;
    localparam int SETTLE         = 32;
    localparam int TIMEOUT_CYCLES = NUM_WORDS * 3 + BP_MAX + 2 * SETTLE + 200;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] imem_rdata = 32'h0;
    logic        imem_resp  = 1'b0;
    logic        rs_full    = 1'b0;
    logic        dispatch_valid;
    logic [31:0] dispatch_pc  [SS];
    logic [4:0]  dispatch_rd  [SS];
    logic [5:0]  dispatch_ps1 [SS];
    logic [5:0]  dispatch_ps2 [SS];
    logic [5:0]  dispatch_pd  [SS];

    // Program, response gaps and predicted packets
    logic [31:0] prog [NUM_WORDS];
    logic [1:0]  gap  [256];
    logic [31:0] exp_pc  [NUM_PAIRS][SS];
    logic [31:0] exp_rd  [NUM_PAIRS][SS];
    logic [31:0] exp_ps1 [NUM_PAIRS][SS];
    logic [31:0] exp_ps2 [NUM_PAIRS][SS];
    logic [31:0] exp_pd  [NUM_PAIRS][SS];

    logic [31:0] seed       = 32'd72327;
    logic [1:0]  wait_cnt   = 2'd0;
    logic [7:0]  resp_cnt   = 8'd0;
    logic        rs_full_q  = 1'b0;
    int          cycles     = 0;
    int          pairs_seen = 0;
    int          err_reset  = 0;
    int          err_rename = 0;
    int          err_dep    = 0;
    int          err_bp     = 0;
    int          err_exh    = 0;
    int          err_stall  = 0;

    tb_clkgen clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cpu DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_addr      (imem_addr),
        .imem_rmask     (imem_rmask),
        .imem_rdata     (imem_rdata),
        .imem_resp      (imem_resp),
        .rs_full        (rs_full),
        .dispatch_valid (dispatch_valid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_rd    (dispatch_rd),
        .dispatch_ps1   (dispatch_ps1),
        .dispatch_ps2   (dispatch_ps2),
        .dispatch_pd    (dispatch_pd)
    );

    // Queue and rename invariants checked inside the core
    bind cpu cpu_chk chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (buf_push),
        .queue_full     (iq_full),
        .pop            (pop_inst_q),
        .queue_empty    (iq_empty),
        .rs_full        (rs_full),
        .dispatch_valid (dispatch_valid)
    );

    // LCG step
    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    // Source and dest use by major opcode, {uses_rs1, uses_rs2, writes_rd}
    function automatic logic [2:0] reg_use(input logic [31:0] word);
        logic [2:0] u;
        case (word[6:0])
            rv32i_types::op_reg:   u = 3'b111;
            rv32i_types::op_imm:   u = 3'b101;
            rv32i_types::op_load:  u = 3'b101;
            rv32i_types::op_jalr:  u = 3'b101;
            rv32i_types::op_store: u = 3'b110;
            rv32i_types::op_br:    u = 3'b110;
            rv32i_types::op_lui:   u = 3'b001;
            rv32i_types::op_auipc: u = 3'b001;
            rv32i_types::op_jal:   u = 3'b001;
            default:               u = 3'b000;
        endcase
        // x0 destination never renamed
        if (word[11:7] == 5'd0) begin
            u[0] = 1'b0;
        end
        return u;
    endfunction

    function automatic void gen_program();
        logic [31:0] r;
        logic [6:0]  opc;
        for (int w = 0; w < NUM_WORDS; w++) begin
            r = rand_next();
            case (r % 32'd6)
                0:       opc = rv32i_types::op_reg;
                1:       opc = rv32i_types::op_imm;
                2:       opc = rv32i_types::op_load;
                3:       opc = rv32i_types::op_store;
                4:       opc = rv32i_types::op_br;
                default: opc = rv32i_types::op_lui;
            endcase
            r = rand_next();
            // Registers from x0..x7 so hazards are frequent
            prog[w] = {r[31:25], 2'b00, r[2:0], 2'b00, r[5:3], r[16:14],
                       2'b00, r[8:6], opc};
        end
        // Pair 3, slot 1 reads slot 0's rd twice
        prog[6]  = {7'd0, 5'd2, 5'd1, 3'd0, 5'd5, rv32i_types::op_reg};
        prog[7]  = {7'd0, 5'd5, 5'd5, 3'd0, 5'd6, rv32i_types::op_reg};
        // Pair 4, both slots write x7 and slot 1 reads it
        prog[8]  = {12'd1, 5'd3, 3'd0, 5'd7, rv32i_types::op_imm};
        prog[9]  = {12'd2, 5'd7, 3'd0, 5'd7, rv32i_types::op_imm};
        // Pair 5 must see pair 4 slot 1's x7
        prog[10] = {7'd0, 5'd7, 5'd7, 3'd0, 5'd9, rv32i_types::op_reg};
        for (int i = 0; i < 256; i++) begin
            gap[i] = 2'(rand_next() % 32'd3);
        end
    endfunction

    // Rename in strict program order, one slot after another
    function automatic void model_rename();
        logic [31:0] map [32];
        logic [31:0] tag;
        logic [31:0] w;
        logic [2:0]  u;
        for (int i = 0; i < 32; i++) begin
            map[i] = 32'(i);
        end
        tag = 32'(rv32i_types::NUM_ARCH_REGS);
        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int s = 0; s < SS; s++) begin
                w = prog[p * SS + s];
                u = reg_use(w);
                exp_pc[p][s]  = 32'((p * SS + s) * 4);
                exp_rd[p][s]  = 32'(w[11:7]);
                exp_ps1[p][s] = u[2] ? map[w[19:15]] : 32'd0;
                exp_ps2[p][s] = u[1] ? map[w[24:20]] : 32'd0;
                exp_pd[p][s]  = u[0] ? tag : 32'd0;
                if (u[0]) begin
                    map[w[11:7]] = tag;
                end
                // Tag consumed even when nothing is written
                tag = tag + 32'd1;
            end
        end
    endfunction

    // Beyond the program an ADDI x0 carrying the folded address
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < 32'(NUM_WORDS * 4)) begin
            return prog[addr[7:2]];
        end
        return {addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]}, 20'h00013};
    endfunction

    task automatic check(input string name, input logic [31:0] exp,
                         input logic [31:0] act, inout int errs);
        if (exp !== act) begin
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act);
            errs++;
        end
    endtask

    function automatic int report(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("Test %0d %s: ok", num, name);
            return 0;
        end
        $display("Test %0d %s: %0d errors", num, name, errs);
        return 1;
    endfunction

    task automatic compare_pair(input int p);
        for (int s = 0; s < SS; s++) begin
            check($sformatf("pair %0d dispatch_pc[%0d]", p, s), exp_pc[p][s],
                  dispatch_pc[s], err_rename);
            check($sformatf("pair %0d dispatch_rd[%0d]", p, s), exp_rd[p][s],
                  32'(dispatch_rd[s]), err_rename);
            check($sformatf("pair %0d dispatch_ps1[%0d]", p, s), exp_ps1[p][s],
                  32'(dispatch_ps1[s]), err_rename);
            check($sformatf("pair %0d dispatch_ps2[%0d]", p, s), exp_ps2[p][s],
                  32'(dispatch_ps2[s]), err_rename);
            check($sformatf("pair %0d dispatch_pd[%0d]", p, s), exp_pd[p][s],
                  32'(dispatch_pd[s]), err_rename);
        end
        // Directed dependency pairs
        if (p == 3) begin
            check("pair 3 dispatch_ps1[1]", exp_pd[3][0], 32'(dispatch_ps1[1]), err_dep);
            check("pair 3 dispatch_ps2[1]", exp_pd[3][0], 32'(dispatch_ps2[1]), err_dep);
        end
        if (p == 4) begin
            check("pair 4 dispatch_ps1[1]", exp_pd[4][0], 32'(dispatch_ps1[1]), err_dep);
        end
        if (p == 5) begin
            check("pair 5 dispatch_ps1[0]", exp_pd[4][1], 32'(dispatch_ps1[0]), err_dep);
        end
    endtask

    // Memory model, one-cycle response pulse then a random idle gap
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_resp <= 1'b0;
            wait_cnt  <= 2'd0;
        end else if (imem_resp) begin
            imem_resp <= 1'b0;
            wait_cnt  <= gap[resp_cnt];
            resp_cnt  <= resp_cnt + 8'd1;
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            // Same address answered again if the last pulse was refused
            imem_resp  <= 1'b1;
            imem_rdata <= fetch_word(imem_addr);
        end
    end

    // Packet compare
    always @(posedge clk) begin
        if (rst_n) begin
            // rs_full one cycle back gated the pop behind this packet
            if (dispatch_valid && rs_full_q) begin
                $display("Fail at %0t: dispatch_valid high while rs_full was held", $time);
                err_bp++;
            end
            if (dispatch_valid) begin
                if (pairs_seen >= NUM_PAIRS) begin
                    $display("Extra dispatch at %0t after the free list ran out", $time);
                    err_exh++;
                end else begin
                    compare_pair(pairs_seen);
                end
                pairs_seen++;
            end
        end
        rs_full_q <= rs_full;
    end

    // Timeout
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d pairs dispatched",
                     cycles, pairs_seen);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int          bp_len;
        int          stable;
        int          bad_tests;
        int          total_errs;
        logic [31:0] last_addr;
        gen_program();
        model_rename();
        bp_len = BP_MIN + int'(rand_next() % 32'(BP_MAX - BP_MIN + 1));

        // Reset state, skipping the edge before reset has taken hold
        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
            check("dispatch_valid", 32'd0, 32'(dispatch_valid), err_reset);
            check("imem_addr", 32'd0, imem_addr, err_reset);
            check("imem_rmask", 32'hf, 32'(imem_rmask), err_reset);
        end
        @(posedge clk);
        check("dispatch_valid", 32'd0, 32'(dispatch_valid), err_reset);
        check("imem_addr", 32'd0, imem_addr, err_reset);
        check("imem_rmask", 32'hf, 32'(imem_rmask), err_reset);
        bad_tests = report(1, "reset state", err_reset);

        // Back-pressure window after the directed pairs are out
        while (pairs_seen < BP_START) begin
            @(posedge clk);
        end
        rs_full <= 1'b1;
        repeat (bp_len) @(posedge clk);
        rs_full <= 1'b0;

        // Free list runs dry, fetch stalls once the queue is full
        while (pairs_seen < NUM_PAIRS) begin
            @(posedge clk);
        end
        stable    = 0;
        last_addr = imem_addr;
        while (stable < SETTLE) begin
            @(posedge clk);
            if (imem_addr == last_addr) begin
                stable++;
            end else begin
                stable    = 0;
                last_addr = imem_addr;
            end
        end
        check("imem_addr", 32'((NUM_PAIRS + rv32i_types::IQ_DEPTH) * SS * 4),
              imem_addr, err_stall);
        repeat (SETTLE) @(posedge clk);
        check("dispatched pairs", 32'(NUM_PAIRS), 32'(pairs_seen), err_stall);

        bad_tests  = bad_tests + report(2, "straight-line rename", err_rename);
        bad_tests  = bad_tests + report(3, "in-pair dependency", err_dep);
        bad_tests  = bad_tests + report(4, "back-pressure", err_bp);
        bad_tests  = bad_tests + report(5, "free-list exhaustion", err_exh + err_stall);
        total_errs = err_reset + err_rename + err_dep + err_bp + err_exh + err_stall;
        $display("Summary: %0d of 5 tests with errors, %0d failed checks",
                 bad_tests, total_errs);
        if (bad_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
rv32i_types.sv
rat_if.sv
fetch_stage.sv
id_stage.sv
two_inst_buff.sv
circular_queue.sv
rat.sv
rename_dispatch.sv
cpu.sv
tb_clkgen.sv
cpu_chk.sv
cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
